//--- hdl/video_timing_pkg.sv
`default_nettype none

// dram cycle and line timing for the video fetch
package video_timing_pkg;

	localparam int PHASES       = 4;   // clk per dram cycle
	localparam int FETCH_CYCLES = 16;  // dram cycles per fetch cycle, 64 clk
	localparam int LINE_CYCLES  = 64;  // dram cycles per line
	localparam int FETCH_END    = 32;  // window closes here, two fetch cycles
	localparam int BUF_WORDS    = 4;   // words per fetch block

	// c2/c3 come once every C_PERIOD dram cycles
	localparam int C_PERIOD = 4;

	localparam int PH_W   = $clog2(PHASES);
	localparam int LINE_W = $clog2(LINE_CYCLES);
	localparam int SYNC_W = $clog2(FETCH_CYCLES / C_PERIOD);  // fetch sync counter
	localparam int PTR_W  = $clog2(BUF_WORDS);                // fill pointer

	// where the current clk sits in the dram cycle and in the line
	typedef struct packed {
		logic              q0;        // first clk of a dram cycle
		logic              c2;        // q0 of cycles with line_pos mod 4 == 2
		logic              c3;        // same, mod 4 == 3
		logic [LINE_W-1:0] line_pos;  // dram cycle within the line
	} dram_phase_t;

endpackage

`default_nettype wire

//--- hdl/video_data_pkg.sv
`default_nettype none

// payload and colour types shared by the fetch buffers and the renderer
package video_data_pkg;

	localparam int PIX_BLOCK    = 64;                      // pixels per fetch block
	localparam int PIX_PER_ATTR = 8;                       // one attribute covers 8 pixels
	localparam int ATTRS        = PIX_BLOCK / PIX_PER_ATTR;
	localparam int CNT_W        = $clog2(PIX_BLOCK + 1);   // holds 0..64
	localparam int ATTR_SEL_W   = $clog2(ATTRS);

	// two pixel bytes, high byte goes on screen first
	typedef logic [15:0] pix_word_t;

	typedef struct packed {
		logic       spare;   // flash bit on the real thing, not used
		logic       bright;
		logic [2:0] paper;   // colour for 0 bits
		logic [2:0] ink;     // colour for 1 bits
	} attr_t;

	typedef struct packed {
		attr_t hi;  // first attribute
		attr_t lo;
	} attr_word_t;

	typedef struct packed {
		logic       bright;
		logic [2:0] index;
	} colour_t;

	typedef logic [PIX_BLOCK-1:0] pix_block_t;   // bit 63 is the first pixel
	typedef attr_t [0:ATTRS-1]     attr_block_t;  // element 0 is the first attribute

endpackage

`default_nettype wire

//--- hdl/video_phase.sv
`timescale 1ns/1ns
`default_nettype none

// dram phase strobes, line position and fetch window
// words from the arbiter are expected between ptr_clr (line_pos mod 16 == 2)
// and fetch_sync (line_pos mod 16 == 14)
module video_phase
	import video_timing_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        vpix,         // vertical window, from outside
	output dram_phase_t phase,
	output logic        fetch_start,  // q0 of line_pos 0
	output logic        fetch_end,    // q0 of line_pos FETCH_END
	output logic        fetch_sync,   // block handover, once per fetch cycle
	output logic        ptr_clr,      // resync of the fill pointers
	output logic        video_go,     // request window
	output logic        render_en     // window as seen at the last handover
);

	logic [PH_W-1:0]   ph_cnt;    // clk within dram cycle
	logic [LINE_W-1:0] line_pos;
	logic [SYNC_W-1:0] sync_ctr;  // counts c3 down through a fetch cycle
	logic              q0;

	// preset to the last phase so q0 stays low in reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ph_cnt   <= PH_W'(PHASES - 1);
			line_pos <= LINE_W'(LINE_CYCLES - 1);
		end
		else
		begin
			if (ph_cnt == PH_W'(PHASES - 1))
			begin
				ph_cnt <= '0;
				// step to the next dram cycle
				line_pos <= (line_pos == LINE_W'(LINE_CYCLES - 1)) ? '0 : line_pos + 1'b1;
			end
			else
				ph_cnt <= ph_cnt + 1'b1;
		end
	end

	assign q0 = (ph_cnt == '0);

	assign phase.q0       = q0;
	assign phase.c2       = q0 && (line_pos[1:0] == 2'd2);
	assign phase.c3       = q0 && (line_pos[1:0] == 2'd3);
	assign phase.line_pos = line_pos;

	assign fetch_start = q0 && (line_pos == '0);
	assign fetch_end   = q0 && (line_pos == LINE_W'(FETCH_END));

	// counting down puts the handover at the tail of each fetch cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sync_ctr <= '0;
		else if (fetch_start)
			sync_ctr <= '0;                 // realign every line
		else if (phase.c3)
			sync_ctr <= sync_ctr - 1'b1;
	end

	assign fetch_sync = phase.c2 && (sync_ctr == SYNC_W'(1));  // line_pos 14, 30, 46, 62
	assign ptr_clr    = phase.c2 && (sync_ctr == '0);          // line_pos 2, 18, 34, 50

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			video_go <= 1'b0;
		else if (fetch_start && vpix)
			video_go <= 1'b1;
		else if (fetch_end)
			video_go <= 1'b0;
	end

	// a block handed over is valid if it was fetched inside the window
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			render_en <= 1'b0;
		else if (fetch_sync)
			render_en <= video_go;
	end

	// handover two dram cycles before the fetch cycle ends
	a_sync_on_q0: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_sync |-> phase.q0
			&& (phase.line_pos % LINE_W'(FETCH_CYCLES)) == LINE_W'(FETCH_CYCLES - 2));

	// a new line starts with the request window closed
	a_start_end: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_start |-> !fetch_end && !video_go);

endmodule

`default_nettype wire

//--- hdl/video_fetch.sv
`timescale 1ns/1ns
`default_nettype none

// four word fetch buffer, fills on arbiter strobes
// and hands the whole block over on fetch_sync
module video_fetch
	import video_timing_pkg::*;
	import video_data_pkg::*;
#(
	parameter type payload_t = pix_word_t
)(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     q0,
	input  logic                     fetch_sync,
	input  logic                     ptr_clr,
	input  payload_t                 data,    // valid with strobe
	input  logic                     strobe,  // single clk, on q0 only
	output payload_t [0:BUF_WORDS-1] block    // word 0 first, to the renderer
);

	logic [PTR_W-1:0]         ptr;      // next slot to fill
	logic [PTR_W-1:0]         wr_ptr;   // slot used this clk
	logic                     wr_en;
	payload_t [0:BUF_WORDS-1] words_q;  // collected words

	assign wr_en = strobe && q0;

	// clear takes effect at once, a word arriving with it goes to slot 0
	assign wr_ptr = ptr_clr ? '0 : ptr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ptr <= '0;
		else if (ptr_clr || wr_en)
			ptr <= wr_ptr + PTR_W'(wr_en);  // wraps after BUF_WORDS
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			words_q <= '0;
		else if (wr_en)
			words_q[wr_ptr] <= data;
	end

	// no strobes in a fetch cycle means the old block repeats
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			block <= '0;
		else if (fetch_sync)
			block <= words_q;  // order kept, high byte first
	end

	// arbiter must only deliver on q0
	a_strobe_q0: assert property (@(posedge clk) disable iff (!rst_n)
		strobe |-> q0);

endmodule

`default_nettype wire

//--- hdl/video_render.sv
`timescale 1ns/1ns
`default_nettype none

// combines pixel and attribute blocks into one colour per clk
module video_render
	import video_data_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        fetch_sync,
	input  logic        render_en,
	input  pix_block_t  pix,
	input  attr_block_t attr,
	output colour_t     colour,
	output logic        colour_valid
);

	logic                  load_pend;  // handover happened last clk
	logic                  load;
	pix_block_t            pix_q;      // msb is the pixel on screen
	attr_block_t           attr_q;
	logic [CNT_W-1:0]      cnt;        // pixels left in the block
	logic [CNT_W-1:0]      pix_idx;    // 0..63 within the block
	logic [ATTR_SEL_W-1:0] attr_sel;
	attr_t                 cur_attr;

	// blocks settle in the fetch buffers on the fetch_sync edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			load_pend <= 1'b0;
		else
			load_pend <= fetch_sync;
	end

	assign load = load_pend && render_en;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (load)
			cnt <= CNT_W'(PIX_BLOCK);
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	// block registers, pixels move up one place per clk
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			pix_q  <= pix;
			attr_q <= attr;
		end
		else
			pix_q <= pix_q << 1;
	end

	assign pix_idx  = CNT_W'(PIX_BLOCK) - cnt;
	assign attr_sel = ATTR_SEL_W'(pix_idx / CNT_W'(PIX_PER_ATTR));  // 8 pixels each
	assign cur_attr = attr_q[attr_sel];

	assign colour.bright = cur_attr.bright;
	assign colour.index  = pix_q[PIX_BLOCK-1] ? cur_attr.ink : cur_attr.paper;
	assign colour_valid  = (cnt != '0);

	// a block lasts 64 clk, then output stops or the next block follows
	a_block_len: assert property (@(posedge clk) disable iff (!rst_n)
		load |-> ##(PIX_BLOCK) colour_valid ##1 (!colour_valid || $past(load)));

endmodule

`default_nettype wire

//--- hdl/video_top.sv
`timescale 1ns/1ns
`default_nettype none

// video fetch and render slice
module video_top
	import video_timing_pkg::*;
	import video_data_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       vpix,
	input  pix_word_t  pix_data,
	input  logic       pix_strobe,
	input  attr_word_t attr_data,
	input  logic       attr_strobe,
	output logic       video_go,
	output colour_t    colour,
	output logic       colour_valid
);

	dram_phase_t                phase;
	logic                       fetch_sync;
	logic                       ptr_clr;
	logic                       render_en;
	pix_word_t  [0:BUF_WORDS-1] pix_words;
	attr_word_t [0:BUF_WORDS-1] attr_words;
	pix_block_t                 pix_blk;
	attr_block_t                attr_blk;

	video_phase u_phase (
		.clk         (clk),
		.rst_n       (rst_n),
		.vpix        (vpix),
		.phase       (phase),
		.fetch_start (),
		.fetch_end   (),
		.fetch_sync  (fetch_sync),
		.ptr_clr     (ptr_clr),
		.video_go    (video_go),
		.render_en   (render_en)
	);

	video_fetch #(.payload_t(pix_word_t)) pix_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.q0         (phase.q0),
		.fetch_sync (fetch_sync),
		.ptr_clr    (ptr_clr),
		.data       (pix_data),
		.strobe     (pix_strobe),
		.block      (pix_words)
	);

	video_fetch #(.payload_t(attr_word_t)) attr_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.q0         (phase.q0),
		.fetch_sync (fetch_sync),
		.ptr_clr    (ptr_clr),
		.data       (attr_data),
		.strobe     (attr_strobe),
		.block      (attr_words)
	);

	// word 0 lands in the top bits, so the first pixel is bit 63
	assign pix_blk  = pix_block_t'(pix_words);
	assign attr_blk = attr_block_t'(attr_words);  // hi attribute of word 0 is element 0

	video_render u_render (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_sync   (fetch_sync),
		.render_en    (render_en),
		.pix          (pix_blk),
		.attr         (attr_blk),
		.colour       (colour),
		.colour_valid (colour_valid)
	);

endmodule

`default_nettype wire

//--- tb/video_tb.sv
`timescale 1ns/1ns
`default_nettype none

// directed testbench for video_top with a dram arbiter model
module video_tb
	import video_timing_pkg::*;
	import video_data_pkg::*;
();

	localparam int LINE_CLKS  = LINE_CYCLES * PHASES;
	localparam int SYNC_LP    = FETCH_CYCLES - 2;                          // handover dram cycle
	localparam int VALID_CLKS = (FETCH_END / FETCH_CYCLES) * PIX_BLOCK;  // colours per line
	localparam int WORD_PIX   = $bits(pix_word_t);
	localparam int PIX_RANDOM = 0;
	localparam int PIX_ONES   = 1;
	localparam int PIX_ZEROS  = 2;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       vpix;
	pix_word_t  pix_data;
	logic       pix_strobe;
	attr_word_t attr_data;
	logic       attr_strobe;
	logic       video_go;
	colour_t    colour;
	logic       colour_valid;

	pix_word_t  pw_buf [BUF_WORDS];  // words sent in the current fetch cycle
	attr_word_t aw_buf [BUF_WORDS];
	colour_t    exp_q [$];           // colours still to be shown
	int         value_errs = 0;
	int         other_errs = 0;

	always #4 clk = ~clk;

	video_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.vpix         (vpix),
		.pix_data     (pix_data),
		.pix_strobe   (pix_strobe),
		.attr_data    (attr_data),
		.attr_strobe  (attr_strobe),
		.video_go     (video_go),
		.colour       (colour),
		.colour_valid (colour_valid)
	);

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp)
		begin
			value_errs++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errs++;
			$display("ERR %0t %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			value_errs++;
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	// colour of pixel i in the block, high byte first, hi attr first
	function automatic colour_t ref_colour(input int i);
		logic [PTR_W-1:0] w_sel;
		logic [3:0]       b_sel;
		attr_t            a;
		colour_t          c;
		w_sel = PTR_W'(i / WORD_PIX);
		b_sel = 4'(WORD_PIX - 1 - i % WORD_PIX);
		a = ((i / PIX_PER_ATTR) % 2 == 0) ? aw_buf[w_sel].hi : aw_buf[w_sel].lo;
		c.bright = a.bright;
		c.index  = pw_buf[w_sel][b_sel] ? a.ink : a.paper;
		return c;
	endfunction

	task automatic push_block();
		for (int i = 0; i < PIX_BLOCK; i++)
			exp_q.push_back(ref_colour(i));
	endtask

	// one word of each kind on q0 of dram cycles 4, 6, 8, 10 of a fetch cycle
	task automatic drive_arbiter(input int mode);
		int               lp;
		logic [PTR_W-1:0] slot;
		lp = int'(uut.phase.line_pos) % FETCH_CYCLES;
		pix_strobe  = 1'b0;
		attr_strobe = 1'b0;
		if (uut.phase.q0 && video_go && lp >= 4 && lp <= 10 && lp % 2 == 0)
		begin
			slot = PTR_W'((lp - 4) / 2);
			case (mode)
				PIX_ONES:  pw_buf[slot] = '1;
				PIX_ZEROS: pw_buf[slot] = '0;
				default:   pw_buf[slot] = pix_word_t'($urandom);
			endcase
			aw_buf[slot] = attr_word_t'($urandom);
			pix_data     = pw_buf[slot];
			attr_data    = aw_buf[slot];
			pix_strobe   = 1'b1;
			attr_strobe  = 1'b1;
			if (slot == PTR_W'(BUF_WORDS - 1))
				push_block();  // block complete
		end
	endtask

	// returns on the falling edge inside the q0 clk of line_pos 0
	task automatic sync_line_start();
		int n;
		n = 0;
		@(negedge clk);
		while (!(uut.phase.q0 && uut.phase.line_pos == '0))
		begin
			check_bit("video_go", video_go, 1'b0);  // vpix low in the gap line
			check_bit("colour_valid", colour_valid, 1'b0);
			if (n > LINE_CLKS + 8)
			begin
				other_errs++;
				$display("timeout waiting for the start of a line");
				break;
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic run_lines(input int lines, input logic vpix_on, input int mode);
		int      pos;
		int      rises;
		int      nvalid;
		logic    go_prev;
		logic    go_exp;
		logic    valid_exp;
		colour_t exp;
		sync_line_start();
		vpix    = vpix_on;  // sampled at fetch_start
		go_prev = 1'b0;
		rises   = 0;
		nvalid  = 0;
		for (int i = 0; i < lines * LINE_CLKS; i++)
		begin
			pos = i % LINE_CLKS;
			if (pos == 0)
			begin
				rises  = 0;
				nvalid = 0;
			end
			// window opens after fetch_start, closes after fetch_end
			go_exp    = vpix_on && pos >= 1 && pos <= FETCH_END * PHASES;
			valid_exp = vpix_on && pos >= SYNC_LP * PHASES + 2
				&& pos < SYNC_LP * PHASES + 2 + VALID_CLKS;
			check_bit("video_go", video_go, go_exp);
			check_bit("colour_valid", colour_valid, valid_exp);
			if (colour_valid)
			begin
				nvalid++;
				if (exp_q.size() == 0)
				begin
					other_errs++;
					$display("colour_valid high at %0t with no block fetched", $time);
				end
				else
				begin
					exp = exp_q.pop_front();
					check_colour("colour", colour, exp);
				end
			end
			if (video_go && !go_prev)
				rises++;
			go_prev = video_go;
			drive_arbiter(mode);
			if (pos == LINE_CLKS - 1)
			begin
				check_count("valid colours", nvalid, vpix_on ? VALID_CLKS : 0);
				check_count("video_go rises", rises, vpix_on ? 1 : 0);
				check_count("colours left", exp_q.size(), 0);
			end
			@(negedge clk);
		end
		vpix = 1'b0;  // before the next fetch_start
	endtask

	task automatic test_reset_idle();
		run_lines(1, 1'b0, PIX_RANDOM);
	endtask

	task automatic test_window_per_line();
		run_lines(2, 1'b1, PIX_RANDOM);
		run_lines(1, 1'b0, PIX_RANDOM);  // no request, no output
	endtask

	// ink only, then paper only
	task automatic test_solid_pixels();
		run_lines(1, 1'b1, PIX_ONES);
		run_lines(1, 1'b1, PIX_ZEROS);
	endtask

	task automatic test_random_lines();
		run_lines(4, 1'b1, PIX_RANDOM);
	endtask

	initial
	begin
		void'($urandom(32'h5d82));
		rst_n       = 1'b0;
		vpix        = 1'b0;
		pix_data    = '0;
		pix_strobe  = 1'b0;
		attr_data   = '0;
		attr_strobe = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_idle();
		test_window_per_line();
		test_solid_pixels();
		test_random_lines();
		$display("value errors %0d, other errors %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- video_top.f
hdl/video_timing_pkg.sv
hdl/video_data_pkg.sv
hdl/video_phase.sv
hdl/video_fetch.sv
hdl/video_render.sv
hdl/video_top.sv
tb/video_tb.sv

//--- run.sh
#!/bin/sh
# build and run the video testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module video_tb -f video_top.f

./obj_dir/Vvideo_tb > sim.log 2>&1
cat sim.log

# verdict from the log
if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
